// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ecc_mem
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

PASS_LINE := Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the simulation, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_LINE)"

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/ecc_mem_checker.sv ====
`timescale 1ns/100ps
`include "ecc_mem_defs.svh"

module ecc_mem_checker
  import ecc_mem_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  mem_req_t               mem_req_i,
  input  logic                   gnt_i,
  input  mem_rsp_t               mem_rsp_i,
  input  logic                   exp_check_data_i,  // Low when the read data is not compared
  input  logic [`ECC_DATA_W-1:0] exp_rdata_i,
  input  logic [1:0]             exp_flags_i,       // [0] single, [1] multi
  output int unsigned            checks_o,
  output int unsigned            data_errs_o,
  output int unsigned            flag_errs_o,
  output int unsigned            proto_errs_o
);

  typedef struct packed {
    logic                   check_data;
    logic [31:0]            addr;
    logic [`ECC_DATA_W-1:0] rdata;
    logic [1:0]             flags;
  } exp_t;

  exp_t        pending [$];
  exp_t        cur;
  int unsigned checks     = 0;
  int unsigned data_errs  = 0;
  int unsigned flag_errs  = 0;
  int unsigned proto_errs = 0;
  int unsigned low_run    = 0;  // Cycles in a row with a request and no grant
  logic        merge_pending = 1'b0;
  logic        merge_bank    = 1'b0;
  logic        accept;

  assign checks_o     = checks;
  assign data_errs_o  = data_errs;
  assign flag_errs_o  = flag_errs;
  assign proto_errs_o = proto_errs;

  task automatic compare_response(input exp_t e);
    checks++;
    if ({mem_rsp_i.multi_err, mem_rsp_i.single_err} !== e.flags) begin
      flag_errs++;
      $display("ERR %0t: addr %08h flags multi=%0b single=%0b, expected multi=%0b single=%0b",
               $time, e.addr, mem_rsp_i.multi_err, mem_rsp_i.single_err, e.flags[1], e.flags[0]);
    end
    if (e.check_data && (mem_rsp_i.rdata !== e.rdata)) begin
      data_errs++;
      $display("ERR %0t: addr %08h read %08h, expected %08h",
               $time, e.addr, mem_rsp_i.rdata, e.rdata);
    end
  endtask

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      pending.delete();
      low_run       = 0;
      merge_pending = 1'b0;
    end else begin
      // Response to whatever was accepted on the previous edge
      if (pending.size() != 0) begin
        cur = pending.pop_front();
        compare_response(cur);
      end else if (mem_rsp_i.single_err || mem_rsp_i.multi_err) begin
        flag_errs++;
        $display("ERR %0t: error flag raised with no read outstanding", $time);
      end

      // A bank in its merge cycle must hold off a request to itself
      if (mem_req_i.req && merge_pending && (mem_req_i.addr[2] == merge_bank) && gnt_i) begin
        proto_errs++;
        $display("Grant was high at %0t while bank %0d was merging a partial store",
                 $time, merge_bank);
      end

      if (mem_req_i.req && !gnt_i) begin
        low_run++;
      end else begin
        low_run = 0;
      end
      if (low_run == 2) begin
        proto_errs++;
        $display("Grant stayed low for more than one cycle at %0t", $time);
      end

      merge_pending = 1'b0;
      accept = mem_req_i.req && gnt_i;
      if (accept && !mem_req_i.we) begin
        pending.push_back('{exp_check_data_i, mem_req_i.addr, exp_rdata_i, exp_flags_i});
      end else if (accept && (mem_req_i.be != 4'hf)) begin
        // Merge cycle reports on the old word, its data is no response
        pending.push_back('{1'b0, mem_req_i.addr, exp_rdata_i, exp_flags_i});
        merge_pending = 1'b1;
        merge_bank    = mem_req_i.addr[2];
      end
    end
  end

endmodule

// ==== bench/ecc_mem_stim.txt ====
// Columns: kind addr wdata be fault_mask_n exp_rdata exp_flags, all hex
// kind 0 idle, 1 store, 2 load, 3 load comparing flags only; flags bit 0 single, bit 1 multi
1 00000000 deadbeef f 0 0 0
1 00000004 01234567 f 0 0 0
1 00000008 cafef00d f 0 0 0
1 0000000c 89abcdef f 0 0 0
2 00000000 0 0 0 deadbeef 0
2 00000004 0 0 0 01234567 0
2 00000008 0 0 0 cafef00d 0
2 0000000c 0 0 0 89abcdef 0
2 00000404 0 0 0 00000000 0
0 0 0 0 0 0 0
1 00000008 11223344 5 0 0 0
2 00000008 0 0 0 ca22f044 0
1 00000004 ffffffff 8 0 0 0
2 00000000 0 0 0 deadbeef 0
2 00000004 0 0 0 ff234567 0
1 00000010 5a5a5a5a f 0 0 0
1 00000010 5a5a5ada f 7fffffff7f 0 0
2 00000010 0 0 0 5a5a5a5a 1
1 00000014 0f0f0f0f f 0 0 0
1 00000014 0f1f0f0f f 7fffefffff 0 0
2 00000014 0 0 0 0f0f0f0f 1
2 00000010 0 0 0 5a5a5a5a 1
1 00000018 12345678 f 0 0 0
1 00000018 1234567b f 7ffffffffc 0 0
3 00000018 0 0 0 0 2
1 0000001c fedcba98 f 0 0 0
1 0000001c 7edcba90 f 7f7ffffff7 0 0
3 0000001c 0 0 0 0 2
1 00000020 a5a5a5a5 f 0 0 0
1 00000020 b5a5a5a5 f 7fefffffff 0 0
1 00000020 6677c3c3 3 0 0 1
2 00000020 0 0 0 a5a5c3c3 0
0 0 0 0 0 0 0
f 0 0 0 0 0 0

// ==== bench/tb_ecc_mem.sv ====
`timescale 1ns/100ps
`include "ecc_mem_defs.svh"

module tb_ecc_mem
  import ecc_mem_pkg::*;
();

  localparam string       StimFile = "bench/ecc_mem_stim.txt";
  localparam int unsigned Fields   = 7;  // Tokens per stimulus line
  localparam int unsigned MaxLines = 64;

  localparam logic [3:0] KindIdle  = 4'd0;
  localparam logic [3:0] KindStore = 4'd1;
  localparam logic [3:0] KindLoad  = 4'd2;  // KindLoad + 1 compares the flags only

  typedef struct packed {
    logic [3:0]             kind;
    logic [31:0]            addr;
    logic [`ECC_DATA_W-1:0] wdata;
    logic [3:0]             be;
    logic [`ECC_CODE_W-1:0] mask;
    logic [`ECC_DATA_W-1:0] rdata;
    logic [1:0]             flags;
  } op_t;

  logic                   clk = 1'b0;
  logic                   rst_n;
  mem_req_t               mem_req;
  logic [`ECC_CODE_W-1:0] fault_mask_n;
  logic                   gnt;
  mem_rsp_t               mem_rsp;
  logic                   exp_check_data;
  logic [`ECC_DATA_W-1:0] exp_rdata;
  logic [1:0]             exp_flags;
  int unsigned            checks;
  int unsigned            data_errs;
  int unsigned            flag_errs;
  int unsigned            proto_errs;

  logic [63:0] stim_words [Fields*MaxLines];
  int unsigned num_lines   = 0;
  int unsigned setup_errs  = 0;
  logic        stim_loaded = 1'b0;
  logic [31:0] rng;

  always #10 clk = ~clk;

  ecc_mem_top u_dut (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .mem_req_i     (mem_req),
    .fault_mask_ni (fault_mask_n),
    .gnt_o         (gnt),
    .mem_rsp_o     (mem_rsp)
  );

  ecc_mem_checker u_chk (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .mem_req_i        (mem_req),
    .gnt_i            (gnt),
    .mem_rsp_i        (mem_rsp),
    .exp_check_data_i (exp_check_data),
    .exp_rdata_i      (exp_rdata),
    .exp_flags_i      (exp_flags),
    .checks_o         (checks),
    .data_errs_o      (data_errs),
    .flag_errs_o      (flag_errs),
    .proto_errs_o     (proto_errs)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic op_t read_op(input int unsigned n);
    op_t op;
    op.kind  = stim_words[Fields*n][3:0];
    op.addr  = stim_words[Fields*n+1][31:0];
    op.wdata = stim_words[Fields*n+2][`ECC_DATA_W-1:0];
    op.be    = stim_words[Fields*n+3][3:0];
    op.mask  = stim_words[Fields*n+4][`ECC_CODE_W-1:0];
    op.rdata = stim_words[Fields*n+5][`ECC_DATA_W-1:0];
    op.flags = stim_words[Fields*n+6][1:0];
    return op;
  endfunction

  task automatic drive_op(input op_t op);
    mem_req.req    = (op.kind != KindIdle);
    mem_req.we     = (op.kind == KindStore);
    mem_req.addr   = op.addr;
    mem_req.wdata  = op.wdata;
    mem_req.be     = op.be;
    fault_mask_n   = op.mask;
    exp_check_data = (op.kind == KindLoad);
    exp_rdata      = op.rdata;
    exp_flags      = op.flags;
  endtask

  task automatic drive_idle();
    mem_req        = '0;
    fault_mask_n   = '0;  // Every bit written
    exp_check_data = 1'b0;
    exp_rdata      = '0;
    exp_flags      = '0;
  endtask

  function automatic int unsigned total_errors();
    return data_errs + flag_errs + proto_errs + setup_errs;
  endfunction

  task automatic print_summary();
    $display("Errors: %0d data, %0d flag, %0d grant, %0d other, in %0d checked responses",
             data_errs, flag_errs, proto_errs, setup_errs, checks);
  endtask

  initial begin
    op_t         op;
    int unsigned gap;
    rst_n = 1'b0;
    drive_idle();
    rng = 32'hbfc4_22a1;
    for (int unsigned i = 0; i < Fields*MaxLines; i++) begin
      stim_words[i] = '1;  // Reads as an end marker if the file is short
    end
    $readmemh(StimFile, stim_words);
    while (num_lines < MaxLines && stim_words[Fields*num_lines] <= 64'd3) begin
      num_lines++;
    end
    if (num_lines == 0) begin
      $display("No operations could be read from %s", StimFile);
      setup_errs++;
    end
    stim_loaded = 1'b1;

    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int unsigned n = 0; n < num_lines; n++) begin
      op = read_op(n);
      @(negedge clk);
      drive_op(op);
      @(posedge clk);
      // Request stays unchanged until it is granted
      while (op.kind != KindIdle && !(mem_req.req && gnt)) begin
        @(posedge clk);
      end
      // Gaps follow full stores only, so a partial store meets the next request in its merge cycle
      if (op.kind == KindStore && op.be == 4'hf) begin
        rng = xorshift32(rng);
        gap = rng % 3;
        repeat (gap) begin
          @(negedge clk);
          drive_idle();
        end
      end
    end
    @(negedge clk);
    drive_idle();
    repeat (3) @(posedge clk);  // Let the last response be compared

    print_summary();
    if (total_errors() == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    int unsigned cycles;
    int unsigned limit;
    cycles = 0;
    wait (stim_loaded);
    limit = 4 * num_lines + 50;
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the stimulus did not finish within %0d cycles", limit);
    print_summary();
    $display("Testbench failed");
    $finish;
  end

endmodule

// ==== common/ecc_mem_defs.svh ====
`ifndef ECC_MEM_DEFS_SVH
`define ECC_MEM_DEFS_SVH

`define ECC_DATA_W     32  // Unprotected data word
`define ECC_CODE_W     39  // Data plus seven check bits
`define ECC_BANK_WORDS 256
`define ECC_NUM_BANKS  2

// Hsiao parity masks, check bit 6 first and check bit 0 last
`define ECC_HSIAO_MASKS {32'h9850_5586, 32'h2DCC_624C, 32'hC2C1_323B, 32'h3123_4ED1, \
                         32'h413D_89AA, 32'hDEBA_8050, 32'h2606_BD25}

`endif

// ==== common/ecc_mem_pkg.sv ====
`include "ecc_mem_defs.svh"

package ecc_mem_pkg;

  // Check bits of one codeword, also the syndrome width
  typedef logic [`ECC_CODE_W-`ECC_DATA_W-1:0] ecc_check_t;

  // Requester side bus, byte addressed
  typedef struct packed {
    logic                      req;
    logic                      we;    // High for a store
    logic [31:0]               addr;
    logic [`ECC_DATA_W-1:0]    wdata;
    logic [`ECC_DATA_W/8-1:0]  be;
  } mem_req_t;

  typedef struct packed {
    logic [`ECC_DATA_W-1:0] rdata;
    logic                   single_err;
    logic                   multi_err;
  } mem_rsp_t;

  // Raw access into one SRAM bank, word indexed
  typedef struct packed {
    logic                              req;
    logic                              we;
    logic [$clog2(`ECC_BANK_WORDS)-1:0] addr;
    logic [`ECC_CODE_W-1:0]            wdata;
  } bank_acc_t;

  typedef enum logic {
    NORMAL,
    LOAD_AND_STORE
  } store_state_e;

endpackage

// ==== ecc_wrap/ecc_mem_top.sv ====
`timescale 1ns/100ps
`include "ecc_mem_defs.svh"

module ecc_mem_top
  import ecc_mem_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  mem_req_t               mem_req_i,
  input  logic [`ECC_CODE_W-1:0] fault_mask_ni,
  output logic                   gnt_o,
  output mem_rsp_t               mem_rsp_o
);

  localparam int unsigned NumBanks = `ECC_NUM_BANKS;
  localparam int unsigned SelW     = $clog2(NumBanks);

  logic [SelW-1:0]     bank_sel;
  logic [SelW-1:0]     sel_q;
  logic [NumBanks-1:0] bank_gnt;
  mem_req_t            bank_req [NumBanks];
  mem_rsp_t            bank_rsp [NumBanks];

  // Banks interleave on the word address just above the byte offset
  assign bank_sel = mem_req_i.addr[2 +: SelW];

  for (genvar b = 0; b < NumBanks; b++) begin : g_bank
    always_comb begin
      bank_req[b]     = mem_req_i;
      bank_req[b].req = mem_req_i.req && (bank_sel == SelW'(b));
    end

    ecc_sram_wrap u_wrap (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .mem_req_i     (bank_req[b]),
      .fault_mask_ni (fault_mask_ni),
      .gnt_o         (bank_gnt[b]),
      .mem_rsp_o     (bank_rsp[b])
    );
  end

  assign gnt_o = bank_gnt[bank_sel];

  // Remember which bank owns the next response
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q <= '0;
    end else if (mem_req_i.req && gnt_o) begin
      sel_q <= bank_sel;
    end
  end

  assign mem_rsp_o = bank_rsp[sel_q];

endmodule

// ==== ecc_wrap/ecc_sram_wrap.sv ====
`timescale 1ns/100ps
`include "ecc_mem_defs.svh"

module ecc_sram_wrap
  import ecc_mem_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  mem_req_t               mem_req_i,
  input  logic [`ECC_CODE_W-1:0] fault_mask_ni,  // Low bits are written
  output logic                   gnt_o,
  output mem_rsp_t               mem_rsp_o
);

  localparam int unsigned IdxW   = $clog2(`ECC_BANK_WORDS);
  localparam int unsigned IdxLsb = 2 + $clog2(`ECC_NUM_BANKS);  // Skip byte and bank bits
  localparam int unsigned BeW    = `ECC_DATA_W / 8;

  store_state_e state_d, state_q;

  bank_acc_t              bank_acc;
  logic [`ECC_CODE_W-1:0] bank_rdata;
  logic [`ECC_CODE_W-1:0] code_wr;
  logic [`ECC_DATA_W-1:0] loaded;
  logic [`ECC_DATA_W-1:0] to_store;
  logic [`ECC_DATA_W-1:0] be_mask;
  logic [1:0]             ecc_err;

  logic [IdxW-1:0]        req_idx;
  logic [IdxW-1:0]        idx_q;
  logic [`ECC_DATA_W-1:0] wdata_q;
  logic [BeW-1:0]         be_q;

  logic accept;
  logic partial_st;
  logic valid_read_d, valid_read_q;

  assign req_idx    = mem_req_i.addr[IdxLsb+IdxW-1:IdxLsb];
  assign accept     = mem_req_i.req && gnt_o;
  assign partial_st = mem_req_i.we && (mem_req_i.be != '1);

  // Byte enables of the buffered store widened to bit lanes
  always_comb begin
    for (int unsigned b = 0; b < BeW; b++) begin
      be_mask[8*b +: 8] = {8{be_q[b]}};
    end
  end

  always_comb begin
    state_d       = NORMAL;
    gnt_o         = 1'b1;
    to_store      = mem_req_i.wdata;
    bank_acc.req  = mem_req_i.req;
    bank_acc.we   = mem_req_i.we;
    bank_acc.addr = req_idx;
    if (state_q == NORMAL) begin
      if (mem_req_i.req && partial_st) begin
        state_d     = LOAD_AND_STORE;
        bank_acc.we = 1'b0;  // Fetch the old word first
      end
    end else begin
      // Merge cycle, new bytes over the corrected old word
      gnt_o         = 1'b0;
      to_store      = (be_mask & wdata_q) | (~be_mask & loaded);
      bank_acc.req  = 1'b1;
      bank_acc.we   = 1'b1;
      bank_acc.addr = idx_q;
    end
    bank_acc.wdata = code_wr;
  end

  // Store buffer for the merge
  always_ff @(posedge clk_i) begin
    if (accept) begin
      idx_q   <= req_idx;
      wdata_q <= mem_req_i.wdata;
      be_q    <= mem_req_i.be;
    end
  end

  // Partial stores also read, so their old word gets checked
  assign valid_read_d = accept && (!mem_req_i.we || partial_st);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= NORMAL;
      valid_read_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      valid_read_q <= valid_read_d;
    end
  end

  secded_enc u_enc (
    .data_i (to_store),
    .code_o (code_wr)
  );

  secded_dec u_dec (
    .code_i (bank_rdata),
    .data_o (loaded),
    .err_o  (ecc_err)
  );

  sram_bank #(
    .NumWords  (`ECC_BANK_WORDS),
    .DataWidth (`ECC_CODE_W)
  ) u_bank (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (bank_acc.req),
    .we_i     (bank_acc.we),
    .addr_i   (bank_acc.addr),
    .wdata_i  (bank_acc.wdata),
    .bit_en_i (~fault_mask_ni),  // Masked bits keep their stale value
    .rdata_o  (bank_rdata)
  );

  // Flags only mean something in the cycle after a read
  assign mem_rsp_o = '{
    rdata:      loaded,
    single_err: ecc_err[0] && valid_read_q,
    multi_err:  ecc_err[1] && valid_read_q
  };

endmodule

// ==== list.f ====
+incdir+common
common/ecc_mem_pkg.sv
logic/secded_enc.sv
logic/secded_dec.sv
logic/sram_bank.sv
ecc_wrap/ecc_sram_wrap.sv
ecc_wrap/ecc_mem_top.sv
bench/ecc_mem_checker.sv
bench/tb_ecc_mem.sv

// ==== logic/secded_dec.sv ====
`timescale 1ns/100ps
`include "ecc_mem_defs.svh"

module secded_dec
  import ecc_mem_pkg::*;
(
  input  logic [`ECC_CODE_W-1:0] code_i,
  output logic [`ECC_DATA_W-1:0] data_o,
  output logic [1:0]             err_o   // [0] single, [1] double
);

  localparam int unsigned DataW  = `ECC_DATA_W;
  localparam int unsigned CheckW = $bits(ecc_check_t);
  localparam logic [CheckW-1:0][DataW-1:0] HsiaoMask = `ECC_HSIAO_MASKS;

  logic [DataW-1:0] data_raw;
  ecc_check_t       syndrome;
  ecc_check_t       column;

  assign data_raw = code_i[DataW-1:0];

  // Recomputed parity against the stored check bits
  always_comb begin
    for (int unsigned j = 0; j < CheckW; j++) begin
      syndrome[j] = ^(data_raw & HsiaoMask[j]) ^ code_i[DataW+j];
    end
  end

  // Flip the data bit whose mask column equals the syndrome
  always_comb begin
    data_o = data_raw;
    column = '0;
    for (int unsigned i = 0; i < DataW; i++) begin
      for (int unsigned j = 0; j < CheckW; j++) begin
        column[j] = HsiaoMask[j][i];
      end
      if (syndrome == column) begin
        data_o[i] = ~data_raw[i];
      end
    end
  end

  // Columns are odd weight, so a single flip gives an odd syndrome
  assign err_o[0] = ^syndrome;
  assign err_o[1] = ~(^syndrome) && (syndrome != '0);  // Two flips cancel to even weight

endmodule

// ==== logic/secded_enc.sv ====
`timescale 1ns/100ps
`include "ecc_mem_defs.svh"

module secded_enc
  import ecc_mem_pkg::*;
(
  input  logic [`ECC_DATA_W-1:0] data_i,
  output logic [`ECC_CODE_W-1:0] code_o
);

  localparam int unsigned CheckW = $bits(ecc_check_t);
  localparam logic [CheckW-1:0][`ECC_DATA_W-1:0] HsiaoMask = `ECC_HSIAO_MASKS;

  ecc_check_t check;

  // Every data bit feeds exactly three check bits
  always_comb begin
    for (int unsigned i = 0; i < CheckW; i++) begin
      check[i] = ^(data_i & HsiaoMask[i]);
    end
  end

  // Systematic layout, data stays in the low bits
  assign code_o = {check, data_i};

endmodule

// ==== logic/sram_bank.sv ====
`timescale 1ns/100ps
`include "ecc_mem_defs.svh"

module sram_bank #(
  parameter int unsigned NumWords  = `ECC_BANK_WORDS,
  parameter int unsigned DataWidth = `ECC_CODE_W
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        req_i,
  input  logic                        we_i,
  input  logic [$clog2(NumWords)-1:0] addr_i,
  input  logic [DataWidth-1:0]        wdata_i,
  input  logic [DataWidth-1:0]        bit_en_i,
  output logic [DataWidth-1:0]        rdata_o
);

  logic [DataWidth-1:0] mem_q [NumWords] = '{default: '0};  // Starts as all zero codewords
  logic [DataWidth-1:0] rdata_q;

  // Bits with a cleared enable keep their old value
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      mem_q[addr_i] <= (wdata_i & bit_en_i) | (mem_q[addr_i] & ~bit_en_i);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (req_i && !we_i) begin
      rdata_q <= mem_q[addr_i];  // Held until the next read
    end
  end

  assign rdata_o = rdata_q;

endmodule
